// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f uart_top.f \
   --top-module tb_uart_top -o sim_uart

# Let assertion failures reach the closing report of the testbench.
./obj_dir/sim_uart +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "Simulation passed."
else
   echo "Simulation failed."
   exit 1
fi

// ==== tb_uart_top.sv ====
/*
 * Testbench of the UART peripheral.
 * AXI4-Lite master tasks drive the register block while the transmit
 * line is looped back into the receiver.
 */
`include "uart_config.svh"

module tb_uart_top;

   localparam int CPB   = `UART_CLKS_PER_BIT;
   localparam int DEPTH = `UART_FIFO_DEPTH;
   localparam int LIMIT = 20 * CPB;  // Cycles per bus wait, polls per status wait.

   logic                 clk;
   logic                 nrst;
   logic                 gap_high;  // Holds the looped-back line idle.
   logic                 rx_line;
   logic                 tx_line;
   logic                 awvalid;
   uart_pkg::axil_addr_t awaddr;
   logic                 awready;
   logic                 wvalid;
   uart_pkg::axil_data_t wdata;
   logic                 wready;
   logic                 bvalid;
   uart_pkg::axil_resp_t bresp;
   logic                 bready;
   logic                 arvalid;
   uart_pkg::axil_addr_t araddr;
   logic                 arready;
   logic                 rvalid;
   uart_pkg::axil_data_t rdata;
   uart_pkg::axil_resp_t rresp;
   logic                 rready;
   int                   err_cnt;
   int                   to_cnt;

   assign rx_line = tx_line | gap_high;  // Serial loopback.

   uart_top u_dut (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_rx      (rx_line),
      .o_tx      (tx_line),
      .i_awvalid (awvalid),
      .i_awaddr  (awaddr),
      .o_awready (awready),
      .i_wvalid  (wvalid),
      .i_wdata   (wdata),
      .o_wready  (wready),
      .o_bvalid  (bvalid),
      .o_bresp   (bresp),
      .i_bready  (bready),
      .i_arvalid (arvalid),
      .i_araddr  (araddr),
      .o_arready (arready),
      .o_rvalid  (rvalid),
      .o_rdata   (rdata),
      .o_rresp   (rresp),
      .i_rready  (rready)
   );

   bind uart_top uart_top_sva u_sva (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_tx      (o_tx),
      .i_tx_busy (tx_busy),
      .i_awready (o_awready),
      .i_awaddr  (i_awaddr),
      .i_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .i_bresp   (o_bresp),
      .i_arready (o_arready),
      .i_araddr  (i_araddr),
      .i_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .i_rresp   (o_rresp),
      .i_rdata   (o_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic report_timeout(input string what);
      to_cnt++;
      $display("Timeout while waiting for %s.", what);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else begin
         err_cnt++;
         $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic bus_write(input uart_pkg::axil_addr_t addr, input uart_pkg::axil_data_t data,
                            output uart_pkg::axil_resp_t resp);
      int n;
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!awready && n < LIMIT);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      if (!awready) begin
         report_timeout("the write address and data handshake");
      end else begin
         check_value("write data ready", 32'h1, 32'(wready));  // Taken with the address.
      end
      repeat ($urandom_range(3)) @(posedge clk);  // Hold off bready a little.
      bready <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!bvalid && n < LIMIT);
      resp = bresp;
      bready <= 1'b0;
      if (!bvalid) report_timeout("the write response");
   endtask

   task automatic bus_read(input uart_pkg::axil_addr_t addr, output uart_pkg::axil_data_t data,
                           output uart_pkg::axil_resp_t resp);
      int n;
      arvalid <= 1'b1;
      araddr  <= addr;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!arready && n < LIMIT);
      arvalid <= 1'b0;
      if (!arready) report_timeout("the read address handshake");
      repeat ($urandom_range(3)) @(posedge clk);
      rready <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rvalid && n < LIMIT);
      data = rdata;
      resp = rresp;
      rready <= 1'b0;
      if (!rvalid) report_timeout("the read data");
   endtask

   // Polls STATUS until the masked bits match.
   task automatic wait_status(input logic [3:0] mask, input logic [3:0] want, input string what);
      uart_pkg::axil_data_t st;
      uart_pkg::axil_resp_t resp;
      int n;
      n = 0;
      do begin
         bus_read(`UART_ADDR_STATUS, st, resp);
         n++;
      end while ((st[3:0] & mask) != want && n < LIMIT);
      if ((st[3:0] & mask) != want) report_timeout(what);
   endtask

   task automatic send_byte(input uart_pkg::uart_byte_t b, input string name);
      uart_pkg::axil_resp_t resp;
      wait_status(4'h2, 4'h0, "an idle transmitter");
      bus_write(`UART_ADDR_TXDATA, {24'h0, b}, resp);
      check_value(name, 32'h0, 32'(resp));
   endtask

   initial begin
      uart_pkg::axil_data_t rd;
      uart_pkg::axil_resp_t resp;
      uart_pkg::uart_byte_t b;
      uart_pkg::uart_byte_t sent[$];
      int                   fails;

      void'($urandom(78));
      nrst     = 1'b0;
      gap_high = 1'b1;
      awvalid  = 1'b0;
      awaddr   = '0;
      wvalid   = 1'b0;
      wdata    = '0;
      bready   = 1'b0;
      arvalid  = 1'b0;
      araddr   = '0;
      rready   = 1'b0;
      err_cnt  = 0;
      to_cnt   = 0;
      repeat (8) @(posedge clk);
      nrst     <= 1'b1;
      gap_high <= 1'b0;
      @(posedge clk);

      // Quiet after reset.
      bus_read(`UART_ADDR_STATUS, rd, resp);
      check_value("reset status", 32'h0, rd);
      check_value("reset tx line", 32'h1, 32'(tx_line));

      for (int i = 0; i < 5; i++) begin
         b = 8'($urandom_range(255));
         send_byte(b, "loopback write resp");
         wait_status(4'h1, 4'h1, "a received byte");
         bus_read(`UART_ADDR_RXDATA, rd, resp);
         check_value("loopback data", {24'h0, b}, rd);
      end

      // Second write lands while the first frame is on the line.
      b = 8'($urandom_range(255));
      send_byte(b, "busy first write resp");
      bus_read(`UART_ADDR_STATUS, rd, resp);
      check_value("busy status", 32'h2, rd);
      bus_write(`UART_ADDR_TXDATA, 32'h0000_00a5, resp);
      check_value("write while busy resp", 32'h2, 32'(resp));
      wait_status(4'h1, 4'h1, "a received byte");
      bus_read(`UART_ADDR_RXDATA, rd, resp);
      check_value("busy first byte", {24'h0, b}, rd);
      wait_status(4'h2, 4'h0, "an idle transmitter");
      bus_read(`UART_ADDR_STATUS, rd, resp);
      check_value("dropped byte status", 32'h0, rd);

      for (int i = 0; i <= DEPTH; i++) begin
         b = 8'($urandom_range(255));
         sent.push_back(b);
         send_byte(b, "fill write resp");
      end
      wait_status(4'h6, 4'h4, "the overrun flag");
      bus_read(`UART_ADDR_STATUS, rd, resp);
      check_value("full status", 32'hd, rd);
      for (int i = 0; i < DEPTH; i++) begin
         bus_read(`UART_ADDR_RXDATA, rd, resp);
         check_value("fifo order", {24'h0, sent[i]}, rd);
      end
      bus_read(`UART_ADDR_RXDATA, rd, resp);
      check_value("empty read data", 32'h0, rd);
      check_value("empty read resp", 32'h0, 32'(resp));
      bus_write(`UART_ADDR_STATUS, 32'h4, resp);
      check_value("overrun clear resp", 32'h0, 32'(resp));
      bus_read(`UART_ADDR_STATUS, rd, resp);
      check_value("cleared status", 32'h0, rd);

      // Hole in the register map.
      bus_write(4'hc, 32'h1, resp);
      check_value("unmapped write resp", 32'h2, 32'(resp));
      bus_read(4'hc, rd, resp);
      check_value("unmapped read resp", 32'h2, 32'(resp));

      fails = err_cnt + to_cnt + u_dut.u_sva.fail_cnt;
      $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               err_cnt, to_cnt, u_dut.u_sva.fail_cnt);
      if (fails == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== uart_axil_regs.sv ====
/*
 * AXI4-Lite register block of the UART.
 * TXDATA, RXDATA and STATUS, one outstanding response per direction.
 */
`include "uart_config.svh"

module uart_axil_regs (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   // AXI4-Lite slave.
   input  logic                 i_awvalid,
   input  uart_pkg::axil_addr_t i_awaddr,
   output logic                 o_awready,
   input  logic                 i_wvalid,
   input  uart_pkg::axil_data_t i_wdata,
   output logic                 o_wready,
   output logic                 o_bvalid,
   output uart_pkg::axil_resp_t o_bresp,
   input  logic                 i_bready,
   input  logic                 i_arvalid,
   input  uart_pkg::axil_addr_t i_araddr,
   output logic                 o_arready,
   output logic                 o_rvalid,
   output uart_pkg::axil_data_t o_rdata,
   output uart_pkg::axil_resp_t o_rresp,
   input  logic                 i_rready,
   // UART side.
   output logic                 o_tx_start,
   output uart_pkg::uart_byte_t o_tx_data,
   input  logic                 i_tx_busy,
   input  uart_pkg::uart_byte_t i_rx_data,
   input  logic                 i_rx_empty,
   input  logic                 i_rx_full,
   input  logic                 i_rx_overrun,
   output logic                 o_rx_pop,
   output logic                 o_overrun_clr
);

   localparam uart_pkg::axil_resp_t RESP_OKAY   = 2'b00;
   localparam uart_pkg::axil_resp_t RESP_SLVERR = 2'b10;

   logic                 wr_hs;
   logic                 rd_hs;
   logic                 wr_tx;
   logic                 wr_rx;
   logic                 wr_status;
   logic                 rd_rx;
   uart_pkg::axil_resp_t wr_resp;
   uart_pkg::axil_resp_t rd_resp;
   uart_pkg::axil_data_t rd_word;

   // Address and data are taken together, never while a response waits.
   assign wr_hs     = i_awvalid && i_wvalid && !o_bvalid;
   assign o_awready = wr_hs;
   assign o_wready  = wr_hs;
   assign rd_hs     = i_arvalid && !o_rvalid;
   assign o_arready = rd_hs;

   assign wr_tx     = (i_awaddr == `UART_ADDR_TXDATA);
   assign wr_rx     = (i_awaddr == `UART_ADDR_RXDATA);
   assign wr_status = (i_awaddr == `UART_ADDR_STATUS);
   assign rd_rx     = (i_araddr == `UART_ADDR_RXDATA);

   always_comb begin
      if (wr_tx) wr_resp = i_tx_busy ? RESP_SLVERR : RESP_OKAY;  // Byte dropped when busy.
      else if (wr_rx || wr_status) wr_resp = RESP_OKAY;
      else wr_resp = RESP_SLVERR;
   end

   always_comb begin
      rd_resp = RESP_OKAY;
      rd_word = '0;
      case (i_araddr)
         `UART_ADDR_TXDATA: rd_word = '0;
         `UART_ADDR_RXDATA: rd_word = i_rx_empty ? '0 : {24'h0, i_rx_data};
         `UART_ADDR_STATUS: rd_word = {28'h0, i_rx_full, i_rx_overrun, i_tx_busy, !i_rx_empty};
         default:           rd_resp = RESP_SLVERR;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_bvalid      <= 1'b0;
         o_rvalid      <= 1'b0;
         o_tx_start    <= 1'b0;
         o_rx_pop      <= 1'b0;
         o_overrun_clr <= 1'b0;
      end else begin
         // Side-effect strobes, one cycle each.
         o_tx_start    <= wr_hs && wr_tx && !i_tx_busy;
         o_overrun_clr <= wr_hs && wr_status && i_wdata[2];
         o_rx_pop      <= rd_hs && rd_rx && !i_rx_empty;
         if (wr_hs) o_bvalid <= 1'b1;
         else if (i_bready) o_bvalid <= 1'b0;
         if (rd_hs) o_rvalid <= 1'b1;
         else if (i_rready) o_rvalid <= 1'b0;
      end
   end

   // Response payloads, held until the master takes them.
   always_ff @(posedge i_clk) begin
      if (wr_hs) begin
         o_bresp   <= wr_resp;
         o_tx_data <= i_wdata[7:0];
      end
      if (rd_hs) begin
         o_rresp <= rd_resp;
         o_rdata <= rd_word;
      end
   end

endmodule

// ==== uart_config.svh ====
/*
 * UART peripheral configuration.
 * Serial timing, receive FIFO size and AXI4-Lite register map.
 */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Clocks per serial bit. Even, at least 4.
`define UART_CLKS_PER_BIT 16

// Receive FIFO entries, power of two.
`define UART_FIFO_DEPTH 4

// Register byte offsets.
`define UART_ADDR_TXDATA 4'h0
`define UART_ADDR_RXDATA 4'h4
`define UART_ADDR_STATUS 4'h8

`endif

// ==== uart_pkg.sv ====
/*
 * Shared types of the UART peripheral.
 * Character, AXI4-Lite bus fields and FSM state encodings.
 */
package uart_pkg;

   typedef logic [7:0]  uart_byte_t;   // One serial character.
   typedef logic [3:0]  axil_addr_t;   // Byte address in the register window.
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;   // 0 OKAY, 2 SLVERR.

   // Receiver FSM.
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // Transmitter FSM.
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

// ==== uart_rx.sv ====
/*
 * UART receiver, 8 data bits, fixed baud rate.
 * Finds the start bit, samples each data bit in its middle, LSB first,
 * and flags every received character for one cycle.
 */
`include "uart_config.svh"

module uart_rx (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_rx,
   output uart_pkg::uart_byte_t o_data,
   output logic                 o_valid
);

   localparam int CPB   = `UART_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CPB);

   uart_pkg::rx_state_t state_q;
   logic [CNT_W-1:0]    cnt_q;
   logic [1:0]          sync_q;
   logic                rx_s;
   logic                half_bit;
   logic                full_bit;

   assign rx_s     = sync_q[1];
   assign half_bit = (cnt_q == CNT_W'(CPB/2 - 1));
   assign full_bit = (cnt_q == CNT_W'(CPB - 1));

   // Two-flop synchronizer on the serial input.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync_q <= 2'b11;  // Line idles high.
      end else begin
         sync_q <= {sync_q[0], i_rx};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q <= uart_pkg::RX_IDLE;
         cnt_q   <= '0;
         o_valid <= 1'b0;
      end else begin
         cnt_q   <= cnt_q + 1'b1;
         o_valid <= 1'b0;
         case (state_q)
            uart_pkg::RX_IDLE: begin
               cnt_q <= '0;
               if (!rx_s) state_q <= uart_pkg::RX_START;
            end
            uart_pkg::RX_START: if (half_bit) begin
               cnt_q <= '0;
               // Middle of the start bit. A high line here was only a glitch.
               state_q <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
            end
            uart_pkg::RX_DATA: if (full_bit) begin
               cnt_q <= '0;
               if (o_data[0]) begin  // Marker reached bit 0, eighth sample.
                  state_q <= uart_pkg::RX_STOP;
                  o_valid <= 1'b1;
               end
            end
            uart_pkg::RX_STOP: if (full_bit) state_q <= uart_pkg::RX_IDLE;
            default: state_q <= uart_pkg::RX_IDLE;
         endcase
      end
   end

   // Shift register. The marker in bit 7 walks down and counts the bits.
   always_ff @(posedge i_clk) begin
      if (state_q == uart_pkg::RX_IDLE) begin
         o_data <= 8'h80;
      end else if (state_q == uart_pkg::RX_DATA && full_bit) begin
         o_data <= {rx_s, o_data[7:1]};
      end
   end

endmodule

// ==== uart_rx_fifo.sv ====
/*
 * Receive FIFO. Circular buffer of received characters with a sticky
 * overrun flag for characters that arrive while it is full.
 */
`include "uart_config.svh"

module uart_rx_fifo (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_push,
   input  logic                 i_pop,
   input  logic                 i_overrun_clr,
   input  uart_pkg::uart_byte_t i_data,
   output uart_pkg::uart_byte_t o_data,
   output logic                 o_empty,
   output logic                 o_full,
   output logic                 o_overrun
);

   localparam int DEPTH = `UART_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   uart_pkg::uart_byte_t mem [DEPTH];
   logic [PTR_W-1:0]     wr_ptr_q;
   logic [PTR_W-1:0]     rd_ptr_q;
   logic [PTR_W:0]       count_q;
   logic                 do_push;
   logic                 do_pop;

   assign o_empty = (count_q == '0);
   assign o_full  = (count_q == (PTR_W+1)'(DEPTH));
   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && !o_empty;
   assign o_data  = mem[rd_ptr_q];  // Head entry.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         count_q   <= '0;
         o_overrun <= 1'b0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         if (i_push && o_full) o_overrun <= 1'b1;  // A new loss wins over clear.
         else if (i_overrun_clr) o_overrun <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_push) mem[wr_ptr_q] <= i_data;
   end

endmodule

// ==== uart_top.f ====
+incdir+.
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_rx_fifo.sv
uart_axil_regs.sv
uart_top.sv
uart_top_sva.sv
tb_uart_top.sv

// ==== uart_top.sv ====
/*
 * UART peripheral top level.
 * AXI4-Lite register block in front of a transmitter and a receiver
 * with its receive FIFO.
 */
module uart_top (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_rx,
   output logic                 o_tx,
   input  logic                 i_awvalid,
   input  uart_pkg::axil_addr_t i_awaddr,
   output logic                 o_awready,
   input  logic                 i_wvalid,
   input  uart_pkg::axil_data_t i_wdata,
   output logic                 o_wready,
   output logic                 o_bvalid,
   output uart_pkg::axil_resp_t o_bresp,
   input  logic                 i_bready,
   input  logic                 i_arvalid,
   input  uart_pkg::axil_addr_t i_araddr,
   output logic                 o_arready,
   output logic                 o_rvalid,
   output uart_pkg::axil_data_t o_rdata,
   output uart_pkg::axil_resp_t o_rresp,
   input  logic                 i_rready
);

   logic                 tx_start;
   uart_pkg::uart_byte_t tx_byte;
   logic                 tx_busy;
   logic                 rx_valid;
   uart_pkg::uart_byte_t rx_byte;
   uart_pkg::uart_byte_t fifo_data;
   logic                 fifo_empty;
   logic                 fifo_full;
   logic                 fifo_overrun;
   logic                 pop;
   logic                 overrun_clr;

   uart_axil_regs u_regs (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_awvalid     (i_awvalid),
      .i_awaddr      (i_awaddr),
      .o_awready     (o_awready),
      .i_wvalid      (i_wvalid),
      .i_wdata       (i_wdata),
      .o_wready      (o_wready),
      .o_bvalid      (o_bvalid),
      .o_bresp       (o_bresp),
      .i_bready      (i_bready),
      .i_arvalid     (i_arvalid),
      .i_araddr      (i_araddr),
      .o_arready     (o_arready),
      .o_rvalid      (o_rvalid),
      .o_rdata       (o_rdata),
      .o_rresp       (o_rresp),
      .i_rready      (i_rready),
      .o_tx_start    (tx_start),
      .o_tx_data     (tx_byte),
      .i_tx_busy     (tx_busy),
      .i_rx_data     (fifo_data),
      .i_rx_empty    (fifo_empty),
      .i_rx_full     (fifo_full),
      .i_rx_overrun  (fifo_overrun),
      .o_rx_pop      (pop),
      .o_overrun_clr (overrun_clr)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_data  (tx_byte),
      .o_tx    (o_tx),
      .o_busy  (tx_busy)
   );

   uart_rx u_rx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_rx),
      .o_data  (rx_byte),
      .o_valid (rx_valid)
   );

   // Every received character goes straight into the FIFO.
   uart_rx_fifo u_fifo (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_push        (rx_valid),
      .i_pop         (pop),
      .i_overrun_clr (overrun_clr),
      .i_data        (rx_byte),
      .o_data        (fifo_data),
      .o_empty       (fifo_empty),
      .o_full        (fifo_full),
      .o_overrun     (fifo_overrun)
   );

endmodule

// ==== uart_top_sva.sv ====
/*
 * Bound checks on the UART top level.
 * Serial frame shape on the transmit line and AXI4-Lite response rules.
 */
`include "uart_config.svh"

module uart_top_sva (
   input logic                 i_clk,
   input logic                 i_nrst,
   input logic                 i_tx,
   input logic                 i_tx_busy,
   input logic                 i_awready,
   input uart_pkg::axil_addr_t i_awaddr,
   input logic                 i_bvalid,
   input logic                 i_bready,
   input uart_pkg::axil_resp_t i_bresp,
   input logic                 i_arready,
   input uart_pkg::axil_addr_t i_araddr,
   input logic                 i_rvalid,
   input logic                 i_rready,
   input uart_pkg::axil_resp_t i_rresp,
   input uart_pkg::axil_data_t i_rdata
);

   localparam int CPB = `UART_CLKS_PER_BIT;

   int   fail_cnt = 0;  // Failed checks so far.
   int   pos_q;         // Cycles since the transmitter went busy.
   logic wr_unmapped;
   logic rd_unmapped;

   assign wr_unmapped = (i_awaddr != `UART_ADDR_TXDATA) && (i_awaddr != `UART_ADDR_RXDATA) &&
                        (i_awaddr != `UART_ADDR_STATUS);
   assign rd_unmapped = (i_araddr != `UART_ADDR_TXDATA) && (i_araddr != `UART_ADDR_RXDATA) &&
                        (i_araddr != `UART_ADDR_STATUS);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pos_q <= 0;
      end else if (i_tx_busy) begin
         pos_q <= pos_q + 1;
      end else begin
         pos_q <= 0;  // Next frame starts counting from zero.
      end
   end

   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_tx_busy |-> i_tx)
   else begin
      fail_cnt++;
      $error("Transmit line is low while the transmitter is idle.");
   end

   a_start_bit: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_tx_busy && pos_q < CPB |-> !i_tx)
   else begin
      fail_cnt++;
      $error("Start bit is not low for a full bit period.");
   end

   // Stop bit covers the last bit period of the frame.
   a_stop_bit: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_tx_busy && pos_q >= 9 * CPB |-> i_tx)
   else begin
      fail_cnt++;
      $error("Stop bit is not high for a full bit period.");
   end

   a_frame_len: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $fell(i_tx_busy) |-> pos_q == 10 * CPB)
   else begin
      fail_cnt++;
      $error("Transmitter busy time differs from ten bit periods.");
   end

   a_b_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
   else begin
      fail_cnt++;
      $error("Write response dropped or changed before it was taken.");
   end

   a_r_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_rvalid && !i_rready |=> i_rvalid && $stable(i_rresp) && $stable(i_rdata))
   else begin
      fail_cnt++;
      $error("Read response dropped or changed before it was taken.");
   end

   a_wr_slverr: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_awready && wr_unmapped |=> i_bresp == 2'b10)
   else begin
      fail_cnt++;
      $error("Write to an unmapped address did not return SLVERR.");
   end

   a_rd_slverr: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_arready && rd_unmapped |=> i_rresp == 2'b10)
   else begin
      fail_cnt++;
      $error("Read from an unmapped address did not return SLVERR.");
   end

endmodule

// ==== uart_tx.sv ====
/*
 * UART transmitter, 8 data bits, fixed baud rate.
 * Sends start, data LSB first and stop, busy for the whole frame.
 */
`include "uart_config.svh"

module uart_tx (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_start,
   input  uart_pkg::uart_byte_t i_data,
   output logic                 o_tx,
   output logic                 o_busy
);

   localparam int CPB   = `UART_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CPB);

   uart_pkg::tx_state_t  state_q;
   logic [CNT_W-1:0]     cnt_q;
   logic [2:0]           bit_q;    // Index of the data bit on the line.
   uart_pkg::uart_byte_t shift_q;
   logic                 bit_end;

   assign bit_end = (cnt_q == CNT_W'(CPB - 1));
   assign o_busy  = (state_q != uart_pkg::TX_IDLE);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q <= uart_pkg::TX_IDLE;
         cnt_q   <= '0;
         bit_q   <= '0;
         o_tx    <= 1'b1;
      end else begin
         cnt_q <= cnt_q + 1'b1;
         case (state_q)
            uart_pkg::TX_IDLE: begin
               cnt_q <= '0;
               if (i_start) begin
                  state_q <= uart_pkg::TX_START;
                  o_tx    <= 1'b0;  // Start bit.
               end
            end
            uart_pkg::TX_START: if (bit_end) begin
               cnt_q   <= '0;
               bit_q   <= '0;
               o_tx    <= shift_q[0];
               state_q <= uart_pkg::TX_DATA;
            end
            uart_pkg::TX_DATA: if (bit_end) begin
               cnt_q <= '0;
               bit_q <= bit_q + 1'b1;
               if (bit_q == 3'd7) begin
                  o_tx    <= 1'b1;  // Stop bit.
                  state_q <= uart_pkg::TX_STOP;
               end else begin
                  o_tx <= shift_q[0];
               end
            end
            uart_pkg::TX_STOP: if (bit_end) state_q <= uart_pkg::TX_IDLE;
            default: state_q <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   // Character shifter, next bit always in bit 0.
   always_ff @(posedge i_clk) begin
      if (state_q == uart_pkg::TX_IDLE && i_start) begin
         shift_q <= i_data;
      end else if (bit_end && (state_q == uart_pkg::TX_START ||
                               state_q == uart_pkg::TX_DATA)) begin
         shift_q <= shift_q >> 1;
      end
   end

endmodule
